//--- code_entry.sv
`timescale 1ns/100ps
`include "lock_macros.svh"

module code_entry (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lock_pkg::key_t        key,
    input  logic                  key_strobe,
    input  logic                  back_pulse,
    input  logic                  enter_pulse,
    input  logic                  em_pulse,
    input  lock_pkg::lock_state_t state,
    input  logic                  tamper,
    input  logic                  em_allowed,
    input  lock_pkg::token_t      token,
    input  logic                  token_ready,
    output logic                  grant_unlock,
    output logic                  clear_tamper,
    output logic                  entry_error
);

    typedef logic [`LOCK_DIGIT_CNT_W-1:0] digit_cnt_t;

    localparam digit_cnt_t TOKEN_LEN = digit_cnt_t'(`LOCK_TOKEN_DIGITS);
    localparam digit_cnt_t EM_LEN    = digit_cnt_t'(`LOCK_EM_DIGITS);
    localparam int         BUF_W     = $bits(lock_pkg::code_t);

    lock_pkg::code_t  entry_buf;     // Newest digit in the low nibble
    lock_pkg::token_t entry_low;
    digit_cnt_t       digit_cnt;
    digit_cnt_t       digit_limit;
    logic             em_mode;
    logic             delete_key;
    logic             do_verdict;
    logic             do_em;
    logic             do_delete;
    logic             do_push;
    logic             clear_ok;
    logic             em_ok;
    logic             token_ok;

    assign entry_low   = entry_buf[$bits(lock_pkg::token_t)-1:0];
    assign digit_limit = em_mode ? EM_LEN : TOKEN_LEN;
    assign delete_key  = key_strobe && (key == 4'hE || key == 4'hD);

    // At most one action per cycle, enter wins
    assign do_verdict = enter_pulse && (digit_cnt != '0);
    assign do_em      = !do_verdict && em_pulse && em_allowed;
    assign do_delete  = !do_verdict && !do_em && (back_pulse || delete_key);
    assign do_push    = !do_verdict && !do_em && !do_delete && key_strobe &&
                        (state != lock_pkg::UNLOCKED) && (digit_cnt < digit_limit);

    assign clear_ok = (digit_cnt == TOKEN_LEN) && (entry_low == `LOCK_CLEAR_CODE);
    assign em_ok    = (digit_cnt == EM_LEN) && (entry_buf == `LOCK_EM_CODE);
    assign token_ok = token_ready && (digit_cnt == TOKEN_LEN) && (entry_low == token);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit_cnt    <= '0;
            em_mode      <= 1'b0;
            grant_unlock <= 1'b0;
            clear_tamper <= 1'b0;
            entry_error  <= 1'b0;
        end else begin
            grant_unlock <= 1'b0;
            clear_tamper <= 1'b0;
            entry_error  <= 1'b0;
            if (do_verdict) begin
                digit_cnt <= '0;
                em_mode   <= 1'b0;
                if (em_mode && tamper) begin
                    clear_tamper <= clear_ok;
                    entry_error  <= !clear_ok;
                end else if (em_mode) begin
                    grant_unlock <= em_ok;
                    entry_error  <= !em_ok;
                end else begin
                    grant_unlock <= token_ok;
                    entry_error  <= !token_ok;
                end
            end else if (do_em) begin
                digit_cnt <= '0;
                em_mode   <= 1'b1;
            end else if (do_delete) begin
                if (digit_cnt != '0) begin
                    digit_cnt <= digit_cnt - 1'b1;
                end else begin
                    em_mode <= 1'b0;          // Backspace on empty leaves emergency mode
                end
            end else if (do_push) begin
                digit_cnt <= digit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_verdict || do_em) begin
            entry_buf <= '0;
        end else if (do_delete) begin
            entry_buf <= {4'h0, entry_buf[BUF_W-1:4]};
        end else if (do_push) begin
            entry_buf <= {entry_buf[BUF_W-5:0], key};
        end
    end

endmodule

//--- key_scanner.sv
`timescale 1ns/100ps
`include "lock_macros.svh"

module key_scanner (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [3:0]     col,
    output logic [3:0]     row,
    output lock_pkg::key_t key,
    output logic           key_strobe
);

    typedef logic [`LOCK_SCAN_CNT_W-1:0] scan_cnt_t;

    localparam scan_cnt_t SCAN_LAST  = scan_cnt_t'(`LOCK_SCAN_CYCLES - 1);
    localparam scan_cnt_t SCAN_POINT = scan_cnt_t'(`LOCK_SCAN_SAMPLE);

    scan_cnt_t  scan_cnt;
    logic [3:0] lock_row;      // Row where the held key was found
    logic       press_lock;    // Set from strobe until that row reads idle
    logic       sample_now;
    logic       col_active;
    logic       new_press;

    // One low row and one low column to a hex key
    function automatic lock_pkg::key_t decode_key(input logic [3:0] r, input logic [3:0] c);
        lock_pkg::key_t k;
        k = 4'hC;
        case (c)
            4'b0111: case (r)
                4'b0111: k = 4'h1;
                4'b1011: k = 4'h4;
                4'b1101: k = 4'h7;
                4'b1110: k = 4'hE;
                default: k = 4'hC;
            endcase
            4'b1011: case (r)
                4'b0111: k = 4'h2;
                4'b1011: k = 4'h5;
                4'b1101: k = 4'h8;
                4'b1110: k = 4'h0;
                default: k = 4'hC;
            endcase
            4'b1101: case (r)
                4'b0111: k = 4'h3;
                4'b1011: k = 4'h6;
                4'b1101: k = 4'h9;
                4'b1110: k = 4'hF;
                default: k = 4'hC;
            endcase
            4'b1110: case (r)
                4'b0111: k = 4'hA;
                4'b1011: k = 4'hB;
                4'b1101: k = 4'hC;
                4'b1110: k = 4'hD;
                default: k = 4'hC;
            endcase
            default: k = 4'hC;     // Several columns low at once
        endcase
        return k;
    endfunction

    assign sample_now = (scan_cnt == SCAN_POINT);
    assign col_active = (col != 4'b1111);
    assign new_press  = sample_now && col_active && !press_lock;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt   <= '0;
            row        <= 4'b1110;
            press_lock <= 1'b0;
            key_strobe <= 1'b0;
        end else begin
            key_strobe <= new_press;
            if (scan_cnt == SCAN_LAST) begin
                scan_cnt <= '0;
                row      <= {row[2:0], row[3]};    // Walk the low bit upward
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            if (new_press) begin
                press_lock <= 1'b1;
            end else if (sample_now && !col_active && row == lock_row) begin
                press_lock <= 1'b0;                // Key released
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_press) begin
            key      <= decode_key(row, col);
            lock_row <= row;
        end
    end

endmodule

//--- lock_assertions.sv
`timescale 1ns/100ps

module lock_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input lock_pkg::lock_state_t state,
    input logic                  relay_n,
    input logic                  tamper,
    input logic                  sync_pulse,
    input logic                  grant_unlock,
    input logic                  clear_tamper
);

    // A granted unlock energizes the strike on the next cycle
    grant_opens_relay: assert property (
        @(posedge clk) disable iff (!rst_n)
        (grant_unlock && !tamper && !sync_pulse) |=> (state == lock_pkg::UNLOCKED && !relay_n)
    ) else $error("grant_unlock did not open the lock");

    clear_ends_tamper: assert property (
        @(posedge clk) disable iff (!rst_n)
        (clear_tamper && tamper && !sync_pulse) |=> (state == lock_pkg::LOCKED && !tamper)
    ) else $error("clear_tamper did not return the lock to LOCKED");

    // Tamper latch holds the lock in MALFUNCTION
    tamper_holds_malfunction: assert property (
        @(posedge clk) disable iff (!rst_n) tamper |-> (state == lock_pkg::MALFUNCTION)
    ) else $error("tamper set outside MALFUNCTION");

endmodule

bind lock_controller lock_assertions u_assert (
    .clk(clk),
    .rst_n(rst_n),
    .state(state),
    .relay_n(relay_n),
    .tamper(tamper),
    .sync_pulse(sync_pulse),
    .grant_unlock(grant_unlock),
    .clear_tamper(clear_tamper)
);

//--- lock_controller.sv
`timescale 1ns/100ps
`include "lock_macros.svh"

module lock_controller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  door,          // 1 means open
    input  logic                  sync_pulse,
    input  logic                  grant_unlock,
    input  logic                  clear_tamper,
    output lock_pkg::lock_state_t state,
    output logic                  tamper,
    output logic                  em_allowed,
    output logic                  relay_n
);

    typedef logic [`LOCK_OPEN_CNT_W-1:0] open_cnt_t;

    localparam open_cnt_t OPEN_END  = open_cnt_t'(`LOCK_OPEN_CYCLES);
    localparam open_cnt_t OPEN_LAST = open_cnt_t'(`LOCK_OPEN_CYCLES - 1);
    localparam open_cnt_t GRACE_END = open_cnt_t'(`LOCK_GRACE_CYCLES);

    open_cnt_t open_cnt;     // Cycles since UNLOCKED was entered, saturates
    logic      armed;        // Door watch active
    logic      lockout;      // Emergency button disabled
    logic      door_seen;    // Door opened after grace, relock on close

    // Strike energized only inside the window
    assign relay_n = !((state == lock_pkg::UNLOCKED) && (open_cnt < OPEN_END));

    assign em_allowed = !lockout && !(tamper && door);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if (door) begin
                state <= lock_pkg::MALFUNCTION;    // Wait for door to close
            end else begin
                state <= lock_pkg::LOCKED;
            end
            armed     <= !door;
            tamper    <= 1'b0;
            lockout   <= 1'b0;
            open_cnt  <= '0;
            door_seen <= 1'b0;
        end else if (sync_pulse) begin
            if (tamper) begin
                state   <= lock_pkg::MALFUNCTION;
                lockout <= door;                   // Rearm button only with door shut
            end else if (door) begin
                state   <= lock_pkg::MALFUNCTION;
                tamper  <= 1'b1;
                lockout <= 1'b1;
            end else begin
                state   <= lock_pkg::LOCKED;
                armed   <= 1'b0;
                lockout <= 1'b0;
            end
        end else if (clear_tamper && tamper) begin
            state  <= lock_pkg::LOCKED;
            tamper <= 1'b0;
            armed  <= 1'b1;
        end else if (grant_unlock && !tamper) begin
            state     <= lock_pkg::UNLOCKED;
            open_cnt  <= '0;
            door_seen <= 1'b0;
        end else if (state == lock_pkg::UNLOCKED) begin
            if (open_cnt < OPEN_END) open_cnt <= open_cnt + 1'b1;
            if (door_seen) begin
                if (!door) state <= lock_pkg::LOCKED;
            end else if (door && open_cnt >= GRACE_END) begin
                door_seen <= 1'b1;
            end else if (open_cnt == OPEN_LAST) begin
                state <= lock_pkg::LOCKED;         // Never opened, window over
            end
        end else if (!armed) begin
            if (!door) begin
                armed <= 1'b1;
                state <= lock_pkg::LOCKED;
            end
        end else if (door) begin
            // Forced entry
            state   <= lock_pkg::MALFUNCTION;
            tamper  <= 1'b1;
            lockout <= 1'b1;
        end
    end

endmodule

//--- lock_macros.svh
`ifndef LOCK_MACROS_SVH
`define LOCK_MACROS_SVH

// Keypad scan, clocks per row slot
`define LOCK_SCAN_CYCLES   16
`define LOCK_SCAN_SAMPLE   8       // Columns settle well before this point
`define LOCK_SCAN_CNT_W    4

// Serial token input, clocks per bit
`define LOCK_BIT_CYCLES    16
`define LOCK_BIT_CNT_W     5

// Unlock window
`define LOCK_OPEN_CYCLES   200
`define LOCK_GRACE_CYCLES  20      // Door sensor ignored this long after unlock
`define LOCK_OPEN_CNT_W    8

// Codes, one hex digit per nibble, first digit in the top nibble
`define LOCK_EM_CODE       32'h2716_8899
`define LOCK_CLEAR_CODE    16'h2716

// Entry lengths
`define LOCK_TOKEN_DIGITS  4
`define LOCK_EM_DIGITS     8
`define LOCK_DIGIT_CNT_W   4

`endif

//--- lock_pkg.sv
`include "lock_macros.svh"

package lock_pkg;

    // Lock state as seen by the relay and the keypad logic
    typedef enum logic [1:0] {
        LOCKED      = 2'd0,
        UNLOCKED    = 2'd1,
        MALFUNCTION = 2'd2     // Door forced or open at startup
    } lock_state_t;

    // One keypad key, 0-9 and A-F
    typedef logic [3:0] key_t;

    // Entry buffer, long enough for the emergency code
    typedef logic [`LOCK_EM_DIGITS*4-1:0] code_t;

    // Unlock token loaded over the serial line
    typedef logic [`LOCK_TOKEN_DIGITS*4-1:0] token_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the keypad lock testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_secure_lock \
    -f sources.f -o tb_secure_lock

out=$(./obj_dir/tb_secure_lock || true)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- secure_lock_top.sv
`timescale 1ns/100ps

module secure_lock_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [3:0]            col,
    input  logic                  rx,
    input  logic                  door,
    input  logic                  back_btn,
    input  logic                  enter_btn,
    input  logic                  em_btn,
    input  logic                  sync_btn,
    output logic [3:0]            row,
    output logic                  relay_n,
    output lock_pkg::lock_state_t state,
    output logic                  token_ready,
    output logic                  entry_error
);

    logic [3:0]       btn_prev;      // back, enter, em, sync
    logic             back_pulse;
    logic             enter_pulse;
    logic             em_pulse;
    logic             sync_pulse;
    lock_pkg::key_t   key;
    logic             key_strobe;
    lock_pkg::token_t token;
    logic             grant_unlock;
    logic             clear_tamper;
    logic             tamper;
    logic             em_allowed;

    // Buttons idle high, so previous values start at 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_prev <= 4'b1111;
        end else begin
            btn_prev <= {back_btn, enter_btn, em_btn, sync_btn};
        end
    end

    assign back_pulse  = btn_prev[3] && !back_btn;
    assign enter_pulse = btn_prev[2] && !enter_btn;
    assign em_pulse    = btn_prev[1] && !em_btn;
    assign sync_pulse  = btn_prev[0] && !sync_btn;

    key_scanner u_scan (
        .clk(clk), .rst_n(rst_n), .col(col), .row(row), .key(key), .key_strobe(key_strobe)
    );

    token_receiver u_rx (
        .clk(clk), .rst_n(rst_n), .rx(rx), .token(token), .token_ready(token_ready)
    );

    code_entry u_entry (
        .clk(clk), .rst_n(rst_n), .key(key), .key_strobe(key_strobe),
        .back_pulse(back_pulse), .enter_pulse(enter_pulse), .em_pulse(em_pulse),
        .state(state), .tamper(tamper), .em_allowed(em_allowed),
        .token(token), .token_ready(token_ready),
        .grant_unlock(grant_unlock), .clear_tamper(clear_tamper), .entry_error(entry_error)
    );

    lock_controller u_ctrl (
        .clk(clk), .rst_n(rst_n), .door(door), .sync_pulse(sync_pulse),
        .grant_unlock(grant_unlock), .clear_tamper(clear_tamper),
        .state(state), .tamper(tamper), .em_allowed(em_allowed), .relay_n(relay_n)
    );

endmodule

//--- sources.f
+incdir+.
lock_pkg.sv
key_scanner.sv
token_receiver.sv
code_entry.sv
lock_controller.sv
secure_lock_top.sv
lock_assertions.sv
tb_secure_lock.sv

//--- tb_secure_lock.sv
`timescale 1ns/100ps
`include "lock_macros.svh"

module tb_secure_lock;

    localparam int KEY_WAIT   = 8 * `LOCK_SCAN_CYCLES + 8;
    localparam int OPEN_WAIT  = `LOCK_OPEN_CYCLES + 20;
    localparam int TOKEN_WAIT = 4 * `LOCK_BIT_CYCLES;
    localparam logic [1:0] BACK  = 2'd3;   // Index into btns
    localparam logic [1:0] ENTER = 2'd2;
    localparam logic [1:0] EM    = 2'd1;
    localparam logic [1:0] SYNC  = 2'd0;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  rx;
    logic                  door;
    logic [3:0]            btns;           // back, enter, em, sync
    logic [3:0]            row;
    logic [3:0]            col;
    logic                  relay_n;
    lock_pkg::lock_state_t state;
    logic                  token_ready;
    logic                  entry_error;
    logic                  pressed;
    logic [3:0]            pressed_key;
    logic [7:0]            key_pos;        // Row pattern, column pattern
    logic [15:0]           token_val;
    int                    errors;
    int                    timeouts;
    int                    error_pulses;

    secure_lock_top dut0 (
        .clk(clk), .rst_n(rst_n), .col(col), .rx(rx), .door(door),
        .back_btn(btns[3]), .enter_btn(btns[2]), .em_btn(btns[1]), .sync_btn(btns[0]),
        .row(row), .relay_n(relay_n), .state(state),
        .token_ready(token_ready), .entry_error(entry_error)
    );

    always #50 clk = ~clk;

    // Keypad matrix, where each key sits
    function automatic logic [7:0] key_position(input logic [3:0] k);
        case (k)
            4'h1: key_position = 8'b0111_0111;
            4'h4: key_position = 8'b1011_0111;
            4'h7: key_position = 8'b1101_0111;
            4'hE: key_position = 8'b1110_0111;
            4'h2: key_position = 8'b0111_1011;
            4'h5: key_position = 8'b1011_1011;
            4'h8: key_position = 8'b1101_1011;
            4'h0: key_position = 8'b1110_1011;
            4'h3: key_position = 8'b0111_1101;
            4'h6: key_position = 8'b1011_1101;
            4'h9: key_position = 8'b1101_1101;
            4'hF: key_position = 8'b1110_1101;
            4'hA: key_position = 8'b0111_1110;
            4'hB: key_position = 8'b1011_1110;
            4'hC: key_position = 8'b1101_1110;
            4'hD: key_position = 8'b1110_1110;
        endcase
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h37 + {4'h0, n};
    endfunction

    assign key_pos = key_position(pressed_key);
    assign col     = (pressed && row == key_pos[7:4]) ? key_pos[3:0] : 4'b1111;

    // Count entry_error pulses mid-cycle
    always @(negedge clk) begin
        if (rst_n && entry_error) error_pulses++;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s, got %0h expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0d ns: %s", $time, what);
    endtask

    task automatic press_key(input logic [3:0] k);
        int n;
        n = 0;
        pressed_key = k;
        pressed = 1'b1;
        tick();
        while (!dut0.key_strobe && n < KEY_WAIT) begin
            tick();
            n++;
        end
        if (dut0.key_strobe) check(32'(dut0.key), 32'(k), "decoded key");
        else report_timeout($sformatf("no key strobe for key %h", k));
        pressed = 1'b0;
        n = 0;
        while (dut0.u_scan.press_lock && n < KEY_WAIT) begin
            tick();
            n++;
        end
        if (dut0.u_scan.press_lock) report_timeout("keypad never saw the key released");
    endtask

    // First digit in the top nibble
    task automatic key_code(input logic [31:0] code, input int digits);
        logic [31:0] c;
        c = code << (4 * (8 - digits));
        repeat (digits) begin
            press_key(c[31:28]);
            c = c << 4;
        end
    endtask

    task automatic pulse_button(input logic [1:0] idx);
        btns[idx] = 1'b0;
        tick();
        btns[idx] = 1'b1;
        tick();                            // Verdict now reflected in state
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};           // 8N1, LSB first
        repeat (10) begin
            rx = frame[0];
            frame = {1'b1, frame[9:1]};
            repeat (`LOCK_BIT_CYCLES) tick();
        end
    endtask

    task automatic wait_state(input lock_pkg::lock_state_t s, input int limit, output int n);
        n = 0;
        while (state != s && n < limit) begin
            tick();
            n++;
        end
        if (state != s) report_timeout($sformatf("state never reached %s", s.name()));
    endtask

    task automatic expect_unlocked(input string what);
        check(32'(state), 32'(lock_pkg::UNLOCKED), {what, " state"});
        check(32'(relay_n), 32'd0, {what, " relay"});
    endtask

    task automatic wait_window_end(input string what);
        int n;
        wait_state(lock_pkg::LOCKED, OPEN_WAIT, n);
        check(32'(n >= `LOCK_OPEN_CYCLES - 2 && n <= `LOCK_OPEN_CYCLES + 2), 32'd1,
              {what, " window length"});
        check(32'(relay_n), 32'd1, {what, " relay after relock"});
    endtask

    task automatic test_reset_state();
        logic [3:0] exp_row;
        check(32'(relay_n), 32'd1, "relay after reset");
        check(32'(state), 32'(lock_pkg::LOCKED), "state after reset");
        check(32'(token_ready), 32'd0, "token_ready after reset");
        exp_row = 4'b1110;
        repeat (`LOCK_SCAN_SAMPLE) tick();
        repeat (4) begin
            check(32'(row), 32'(exp_row), "row walk");
            exp_row = {exp_row[2:0], exp_row[3]};
            repeat (`LOCK_SCAN_CYCLES) tick();
        end
    endtask

    task automatic test_emergency_unlock();
        int pulses;
        pulses = error_pulses;
        check(32'(token_ready), 32'd0, "no token before emergency unlock");
        pulse_button(EM);
        key_code(`LOCK_EM_CODE, 8);
        pulse_button(ENTER);
        check(32'(error_pulses - pulses), 32'd0, "emergency code raised entry_error");
        expect_unlocked("emergency unlock");
        wait_window_end("emergency unlock");
    endtask

    task automatic test_token_unlock();
        int d;
        int n;
        logic [15:0] t;
        repeat (4) begin
            d = int'($urandom % 14);       // D and E are backspace keys
            token_val = {token_val[11:0], (d < 13) ? d[3:0] : 4'hF};
        end
        send_byte(8'h21);
        send_byte(8'h49);
        t = token_val;
        repeat (4) begin
            send_byte(hex_char(t[15:12]));
            t = t << 4;
        end
        n = 0;
        while (!token_ready && n < TOKEN_WAIT) begin
            tick();
            n++;
        end
        if (!token_ready) report_timeout("token_ready never rose");
        key_code({16'h0, token_val}, 4);
        pulse_button(ENTER);
        expect_unlocked("token unlock");
        wait_window_end("token unlock");
    endtask

    task automatic test_wrong_code();
        int pulses;
        logic [3:0] bad;
        pulses = error_pulses;
        bad = (token_val[3:0] == 4'h0) ? 4'h1 : 4'h0;
        key_code({16'h0, token_val[15:4], bad}, 4);
        pulse_button(ENTER);
        check(32'(error_pulses - pulses), 32'd1, "entry_error for a wrong code");
        check(32'(state), 32'(lock_pkg::LOCKED), "state after wrong code");
        key_code({16'h0, token_val[15:4], bad}, 4);
        press_key(bad);                    // Fifth digit, over the limit
        pulse_button(BACK);
        press_key(token_val[3:0]);
        pulse_button(ENTER);
        expect_unlocked("corrected code");
        wait_window_end("corrected code");
    endtask

    task automatic test_door_relock();
        int n;
        key_code({16'h0, token_val}, 4);
        pulse_button(ENTER);
        expect_unlocked("door relock");
        repeat (`LOCK_GRACE_CYCLES + 10) tick();
        door = 1'b1;
        repeat (20) tick();
        check(32'(state), 32'(lock_pkg::UNLOCKED), "door held open");
        door = 1'b0;
        wait_state(lock_pkg::LOCKED, 4, n);
        check(32'(relay_n), 32'd1, "relay after door closed");
    endtask

    task automatic test_tamper_clear();
        int pulses;
        int n;
        pulses = error_pulses;
        door = 1'b1;                       // Forced open while locked
        wait_state(lock_pkg::MALFUNCTION, 4, n);
        pulse_button(EM);
        key_code({16'h0, `LOCK_CLEAR_CODE}, 4);
        check(32'(error_pulses - pulses), 32'd0, "entry_error during lockout");
        // Emergency mode refused, so the digits are judged as a token code
        pulse_button(ENTER);
        check(32'(error_pulses - pulses), 32'(token_val != `LOCK_CLEAR_CODE),
              "verdict during lockout");
        check(32'(state), 32'(lock_pkg::MALFUNCTION), "state during lockout");
        pulses = error_pulses;
        door = 1'b0;
        tick();
        pulse_button(SYNC);
        pulse_button(EM);
        key_code({16'h0, `LOCK_CLEAR_CODE}, 4);
        pulse_button(ENTER);
        check(32'(error_pulses - pulses), 32'd0, "entry_error on clear code");
        check(32'(state), 32'(lock_pkg::LOCKED), "state after tamper clear");
    endtask

    initial begin
        void'($urandom(32'h41c073f8));
        errors = 0;
        timeouts = 0;
        error_pulses = 0;
        rst_n = 1'b0;
        rx = 1'b1;
        door = 1'b0;
        btns = 4'b1111;
        pressed = 1'b0;
        pressed_key = 4'h0;
        token_val = 16'h0;
        repeat (3) tick();
        rst_n = 1'b1;
        test_reset_state();
        test_emergency_unlock();           // Before any token is loaded
        test_token_unlock();
        test_wrong_code();
        test_door_relock();
        test_tamper_clear();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- token_receiver.sv
`timescale 1ns/100ps
`include "lock_macros.svh"

module token_receiver (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rx,
    output lock_pkg::token_t token,
    output logic             token_ready
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef logic [`LOCK_BIT_CNT_W-1:0] bit_cnt_t;

    localparam bit_cnt_t BIT_LAST = bit_cnt_t'(`LOCK_BIT_CYCLES - 1);
    localparam bit_cnt_t BIT_MID  = bit_cnt_t'(`LOCK_BIT_CYCLES / 2 - 1);

    rx_state_t   rx_state;
    bit_cnt_t    tick_cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  rx_shift;       // LSB arrives first
    logic        byte_strobe;
    logic [2:0]  parse_pos;      // 0 idle, 1 after '!', 2 to 5 digit slots
    logic [11:0] token_acc;
    logic        byte_is_hex;
    logic [3:0]  byte_nibble;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_state    <= RX_IDLE;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            byte_strobe <= 1'b0;
        end else begin
            byte_strobe <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx) rx_state <= RX_START;
                end
                RX_START: begin
                    if (tick_cnt == BIT_MID) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        rx_state <= rx ? RX_IDLE : RX_DATA;   // Glitch, not a start bit
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick_cnt == BIT_LAST) begin
                        tick_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) rx_state <= RX_STOP;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (tick_cnt == BIT_LAST) begin
                        byte_strobe <= rx;                 // Framing error drops the byte
                        rx_state    <= RX_IDLE;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && tick_cnt == BIT_LAST) rx_shift <= {rx, rx_shift[7:1]};
    end

    // ASCII 0-9 and A-F only
    always_comb begin
        byte_is_hex = 1'b0;
        byte_nibble = rx_shift[3:0];
        if (rx_shift >= 8'h30 && rx_shift <= 8'h39) begin
            byte_is_hex = 1'b1;
        end else if (rx_shift >= 8'h41 && rx_shift <= 8'h46) begin
            byte_is_hex = 1'b1;
            byte_nibble = rx_shift[3:0] + 4'd9;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            parse_pos   <= '0;
            token_ready <= 1'b0;
        end else if (byte_strobe) begin
            if (rx_shift == 8'h21) begin
                parse_pos <= 3'd1;                         // '!' always restarts
            end else if (parse_pos == 3'd1) begin
                parse_pos <= (rx_shift == 8'h49) ? 3'd2 : 3'd0;
            end else if (parse_pos >= 3'd2 && byte_is_hex) begin
                if (parse_pos == 3'd5) begin
                    parse_pos   <= '0;
                    token_ready <= 1'b1;
                end else begin
                    parse_pos <= parse_pos + 1'b1;
                end
            end else begin
                parse_pos <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_strobe && parse_pos >= 3'd2 && byte_is_hex) begin
            token_acc <= {token_acc[7:0], byte_nibble};
            if (parse_pos == 3'd5) token <= {token_acc, byte_nibble};
        end
    end

endmodule
